//--- list.f
common/render_pkg.sv
common/render_ctrl_if.sv
common/vertex_if.sv
config_regs/config_regs.sv
transform/vertex_fetch.sv
transform/vertex_transform.sv
src/render_top.sv
dv/render_sva.sv
dv/render_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= render_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/render_tb.sv
module render_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import render_pkg::*;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
        fix_t w;
        fix_t shade;
    } result_t;

    logic                  clk;
    logic                  reset_n;
    logic [bus_addr_w-1:0] address;
    logic [data_w-1:0]     writedata;
    logic                  write;
    logic                  read;
    logic [data_w-1:0]     readdata;
    mem_addr_t             mem_addr;
    logic                  mem_read;
    logic [data_w-1:0]     mem_readdata;
    logic                  mem_rdvalid;
    fix_t                  out_x;
    fix_t                  out_y;
    fix_t                  out_z;
    fix_t                  out_w;
    fix_t                  out_shade;
    logic                  out_valid;
    logic                  out_ready;

    integer  seed;
    bit      ready_random;
    int      word_errors;
    int      vertex_errors;
    int      other_errors;
    int      mem_reads;
    int      transfers;
    fix_t    mvp_m [16];
    fix_t    light_m [3];
    result_t exp_q [$];

    render_top dut_i (.*);

    always #4 clk = ~clk;

    // memory contents, a hash of the byte address
    function automatic fix_t mem_word(input mem_addr_t a);
        logic [31:0] h;
        h = 32'(a) * 32'h9e37_79b9;
        return fix_t'({{8{h[31]}}, h[31:8]});
    endfunction

    function automatic result_t ref_transform(input fix_t m [16], input fix_t l [3],
                                             input fix_t v [3]);
        longint  acc [5];
        fix_t    coef;
        result_t r;
        for (int i = 0; i < 5; i++) begin
            // rows take w = 1.0, the shade row has no bias
            acc[i] = (i < 4) ? longint'(m[4*i+3]) : 64'sd0;
            for (int j = 0; j < 3; j++) begin
                if (i < 4) begin
                    coef = m[4*i+j];
                end else begin
                    coef = l[j];
                end
                acc[i] += (longint'(coef) * longint'(v[j])) >>> frac_bits;
            end
        end
        r.x = fix_t'(acc[0]);
        r.y = fix_t'(acc[1]);
        r.z = fix_t'(acc[2]);
        r.w = fix_t'(acc[3]);
        r.shade = (fix_t'(acc[4]) < 0) ? fix_t'(0) : fix_t'(acc[4]);
        return r;
    endfunction

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_vertex(input string name, input fix_t got, input fix_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            vertex_errors++;
        end
    endtask

    task automatic write_reg(input logic [bus_addr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge clk);
        #1;
        address   = addr;
        writedata = data;
        write     = 1'b1;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    // readdata is registered, sampled one cycle after read
    task automatic read_reg(input logic [bus_addr_w-1:0] addr, output logic [data_w-1:0] data);
        @(posedge clk);
        #1;
        address = addr;
        read    = 1'b1;
        @(posedge clk);
        #1;
        read = 1'b0;
        data = readdata;
    endtask

    task automatic read_check(input logic [bus_addr_w-1:0] addr, input logic [data_w-1:0] exp,
                              input string name);
        logic [data_w-1:0] v;
        read_reg(addr, v);
        check_word(name, v, exp);
    endtask

    task automatic write_setup();
        for (int i = 0; i < 16; i++) begin
            write_reg(reg_mvp_base + 16'(4 * i), mvp_m[i]);
        end
        for (int i = 0; i < 3; i++) begin
            write_reg(reg_light_base + 16'(4 * i), light_m[i]);
        end
    endtask

    task automatic randomize_setup();
        // roughly -2.0 to 2.0
        for (int i = 0; i < 16; i++) begin
            mvp_m[i] = fix_t'($random(seed)) >>> 14;
        end
        for (int i = 0; i < 3; i++) begin
            light_m[i] = fix_t'($random(seed)) >>> 14;
        end
    endtask

    task automatic push_reference(input mem_addr_t base, input int count);
        fix_t v [3];
        for (int i = 0; i < count; i++) begin
            for (int j = 0; j < 3; j++) begin
                v[j] = mem_word(base + mem_addr_t'(vertex_stride * i + 4 * j));
            end
            exp_q.push_back(ref_transform(mvp_m, light_m, v));
        end
    endtask

    task automatic wait_done(input int limit);
        logic [data_w-1:0] v;
        int                n;
        v = '0;
        n = 0;
        while (v[0] !== 1'b1 && n < limit) begin
            read_reg(reg_control, v);
            n++;
        end
        if (v[0] !== 1'b1) begin
            $display("timeout at %0t, done bit never set", $time);
            other_errors++;
        end
    endtask

    task automatic start_and_wait(input mem_addr_t base, input int count);
        write_reg(reg_vertex_base, 32'(base));
        write_reg(reg_vertex_count, 32'(count));
        write_reg(reg_control, 32'h1);
        read_check(reg_control, 32'h0, "done while running");
        wait_done(1000);
        if (exp_q.size() != 0) begin
            $display("%0d results missing when done was set", exp_q.size());
            other_errors++;
            exp_q.delete();
        end
    endtask

    // one word per read, 0 to 3 cycles late
    initial begin : memory_model
        mem_addr_t a;
        int        d;
        @(posedge clk);
        #1;
        forever begin
            if (mem_read) begin
                a = mem_addr;
                d = $unsigned($random(seed)) % 4;
                mem_reads++;
                repeat (d + 1) @(posedge clk);
                #1;
                mem_rdvalid  = 1'b1;
                mem_readdata = mem_word(a);
                @(posedge clk);
                #1;
                mem_rdvalid = 1'b0;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        out_ready = ready_random ? ($random(seed) % 4 != 0) : 1'b1;
    end

    // handshake is stable at the falling edge
    always @(negedge clk) begin : compare_out
        result_t e;
        if (reset_n && out_valid && out_ready) begin
            transfers++;
            if (exp_q.size() == 0) begin
                $display("output transfer at %0t with no result expected", $time);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                check_vertex("out_x", out_x, e.x);
                check_vertex("out_y", out_y, e.y);
                check_vertex("out_z", out_z, e.z);
                check_vertex("out_w", out_w, e.w);
                check_vertex("out_shade", out_shade, e.shade);
            end
        end
    end

    initial begin
        mem_addr_t a;
        int        reads_before;
        int        xfers_before;
        clk           = 1'b0;
        reset_n       = 1'b0;
        address       = '0;
        writedata     = '0;
        write         = 1'b0;
        read          = 1'b0;
        mem_readdata  = '0;
        mem_rdvalid   = 1'b0;
        out_ready     = 1'b0;
        seed          = 32'h4e79_06c9;
        ready_random  = 1'b0;
        word_errors   = 0;
        vertex_errors = 0;
        other_errors  = 0;
        mem_reads     = 0;
        transfers     = 0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        write_reg(reg_vertex_base, 32'h0012_3450);
        read_check(reg_vertex_base, 32'h0012_3450, "vertex_base");
        write_reg(reg_vertex_count, 32'h0000_abcd);
        read_check(reg_vertex_count, 32'h0000_abcd, "vertex_count");
        randomize_setup();
        write_setup();
        for (int i = 0; i < 16; i++) begin
            read_check(reg_mvp_base + 16'(4 * i), mvp_m[i], $sformatf("mvp[%0d]", i));
        end
        for (int i = 0; i < 3; i++) begin
            read_check(reg_light_base + 16'(4 * i), light_m[i], $sformatf("light[%0d]", i));
        end
        read_check(reg_id, id_value, "id");
        read_check(16'h0010, 32'h0, "unmapped 0x0010");
        read_check(16'h0240, 32'h0, "unmapped 0x0240");
        read_check(16'h030c, 32'h0, "unmapped 0x030c");
        read_check(16'h0504, 32'h0, "unmapped 0x0504");

        // empty job takes done straight from its reset value to 1
        read_check(reg_control, 32'h0, "done after reset");
        reads_before = mem_reads;
        xfers_before = transfers;
        write_reg(reg_vertex_count, 32'h0);
        write_reg(reg_control, 32'h1);
        read_check(reg_control, 32'h1, "done after empty job");
        repeat (20) @(posedge clk);
        if (mem_reads != reads_before || transfers != xfers_before) begin
            $display("empty job caused memory reads or output transfers");
            other_errors++;
        end

        // identity plus translation, light off
        for (int i = 0; i < 16; i++) begin
            mvp_m[i] = (i % 5 == 0) ? fix_t'(32'h0001_0000) : fix_t'(0);
        end
        mvp_m[3]  = fix_t'(32'h0002_8000);
        mvp_m[7]  = fix_t'(32'hfffe_c000);
        mvp_m[11] = fix_t'(32'h0000_4000);
        light_m   = '{fix_t'(0), fix_t'(0), fix_t'(0)};
        write_setup();
        for (int i = 0; i < 4; i++) begin
            a = 26'h000_0100 + mem_addr_t'(vertex_stride * i);
            exp_q.push_back({mem_word(a) + mvp_m[3],
                             mem_word(a + mem_addr_t'(4)) + mvp_m[7],
                             mem_word(a + mem_addr_t'(8)) + mvp_m[11],
                             fix_t'(32'h0001_0000), fix_t'(0)});
        end
        start_and_wait(26'h000_0100, 4);

        // random job under back-pressure, then a restart
        ready_random = 1'b1;
        randomize_setup();
        write_setup();
        push_reference(26'h000_2000, 12);
        start_and_wait(26'h000_2000, 12);
        push_reference(26'h1ff_ff40, 5);
        start_and_wait(26'h1ff_ff40, 5);
        ready_random = 1'b0;

        // light opposite to x, so the dot product is negative
        a          = 26'h000_0300;
        light_m[0] = (mem_word(a) < 0) ? fix_t'(32'h0001_0000) : fix_t'(32'hffff_0000);
        light_m[1] = fix_t'(0);
        light_m[2] = fix_t'(0);
        write_setup();
        push_reference(a, 1);
        start_and_wait(a, 1);

        $display("errors: word %0d vertex %0d other %0d",
                 word_errors, vertex_errors, other_errors);
        if (word_errors + vertex_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- dv/render_sva.sv
module render_sva (
    input logic             clk,
    input logic             reset_n,
    input logic             req,
    input logic             ack,
    input logic             mem_read,
    input logic             mem_rdvalid,
    input logic             out_valid,
    input logic             out_ready,
    input render_pkg::fix_t out_x,
    input render_pkg::fix_t out_y,
    input render_pkg::fix_t out_z,
    input render_pkg::fix_t out_w,
    input render_pkg::fix_t out_shade
);
    timeunit 1ns;
    timeprecision 100ps;

    // one memory read in flight
    logic outstanding;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            outstanding <= 1'b0;
        end else if (mem_read) begin
            outstanding <= 1'b1;
        end else if (mem_rdvalid) begin
            outstanding <= 1'b0;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        req && !ack |=> req)
        else $error("req dropped before ack was seen");

    ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    out_stable: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=>
        out_valid && $stable({out_x, out_y, out_z, out_w, out_shade}))
        else $error("output stream changed while stalled");

    single_read: assert property (@(posedge clk) disable iff (!reset_n)
        mem_read |-> !outstanding)
        else $error("memory read issued with a read outstanding");

endmodule

bind render_top render_sva sva_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (ctrl_if.req),
    .ack         (ctrl_if.ack),
    .mem_read    (mem_read),
    .mem_rdvalid (mem_rdvalid),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_x       (out_x),
    .out_y       (out_y),
    .out_z       (out_z),
    .out_w       (out_w),
    .out_shade   (out_shade)
);

//--- src/render_top.sv
module render_top (
    input  logic                              clk,
    input  logic                              reset_n,

    input  logic [render_pkg::bus_addr_w-1:0] address,
    input  logic [render_pkg::data_w-1:0]     writedata,
    input  logic                              write,
    input  logic                              read,
    output logic [render_pkg::data_w-1:0]     readdata,

    output logic [render_pkg::mem_addr_w-1:0] mem_addr,
    output logic                              mem_read,
    input  logic [render_pkg::data_w-1:0]     mem_readdata,
    input  logic                              mem_rdvalid,

    output render_pkg::fix_t                  out_x,
    output render_pkg::fix_t                  out_y,
    output render_pkg::fix_t                  out_z,
    output render_pkg::fix_t                  out_w,
    output render_pkg::fix_t                  out_shade,
    output logic                              out_valid,
    input  logic                              out_ready
);

    render_ctrl_if ctrl_if ();
    vertex_if      vtx_if ();

    config_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .address   (address),
        .writedata (writedata),
        .write     (write),
        .read      (read),
        .readdata  (readdata),
        .ctrl      (ctrl_if.regs)
    );

    vertex_fetch u_fetch (
        .clk          (clk),
        .reset_n      (reset_n),
        .ctrl         (ctrl_if.engine_fetch),
        .vtx          (vtx_if.source),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read),
        .mem_readdata (mem_readdata),
        .mem_rdvalid  (mem_rdvalid)
    );

    vertex_transform u_xform (
        .clk       (clk),
        .reset_n   (reset_n),
        .ctrl      (ctrl_if.engine_xform),
        .vtx       (vtx_if.sink),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_z     (out_z),
        .out_w     (out_w),
        .out_shade (out_shade),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- transform/vertex_transform.sv
module vertex_transform (
    input  logic                clk,
    input  logic                reset_n,
    render_ctrl_if.engine_xform ctrl,
    vertex_if.sink              vtx,
    output render_pkg::fix_t    out_x,
    output render_pkg::fix_t    out_y,
    output render_pkg::fix_t    out_z,
    output render_pkg::fix_t    out_w,
    output render_pkg::fix_t    out_shade,
    output logic                out_valid,
    input  logic                out_ready
);
    import render_pkg::*;

    xform_state_e state;
    logic [1:0]   row_idx;
    vec3_t        vin;
    logic         cur_last;
    fix_t         res [4];
    fix_t         shade_q;
    fix_t         coef_a;
    fix_t         coef_b;
    fix_t         coef_c;
    fix_t         bias;
    fix_t         dot_sum;
    logic         out_done;
    logic         accept;

    // Q16.16 product from the full 64-bit result
    function automatic fix_t mul_q(fix_t a, fix_t b);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return fix_t'(prod >>> frac_bits);
    endfunction

    assign out_done  = (state == xform_output) && out_ready;
    // next vertex may enter as the current result leaves
    assign vtx.ready = (state == xform_idle) || out_done;
    assign accept    = vtx.valid && vtx.ready;

    assign out_valid = (state == xform_output);
    assign out_x     = res[0];
    assign out_y     = res[1];
    assign out_z     = res[2];
    assign out_w     = res[3];
    assign out_shade = shade_q;

    // three shared multipliers, matrix row or light
    always_comb begin
        if (state == xform_shade) begin
            coef_a = ctrl.light.x;
            coef_b = ctrl.light.y;
            coef_c = ctrl.light.z;
            bias   = '0;
        end else begin
            coef_a = ctrl.mvp[{row_idx, 2'd0}];
            coef_b = ctrl.mvp[{row_idx, 2'd1}];
            coef_c = ctrl.mvp[{row_idx, 2'd2}];
            // w of the vertex is 1.0
            bias   = ctrl.mvp[{row_idx, 2'd3}];
        end
        dot_sum = mul_q(coef_a, vin.x) + mul_q(coef_b, vin.y) + mul_q(coef_c, vin.z) + bias;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            vin <= vtx.vertex;
        end
        if (state == xform_row) begin
            res[row_idx] <= dot_sum;
        end
        if (state == xform_shade) begin
            shade_q <= (dot_sum < 0) ? fix_t'(0) : dot_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= xform_idle;
            row_idx  <= '0;
            cur_last <= 1'b0;
            ctrl.ack <= 1'b0;
        end else begin
            if (accept) begin
                cur_last <= vtx.last;
            end

            // job done once the last result is taken
            if (out_done && cur_last) begin
                ctrl.ack <= 1'b1;
            end else if (ctrl.ack && !ctrl.req) begin
                ctrl.ack <= 1'b0;
            end

            case (state)
                xform_idle: begin
                    if (accept) begin
                        state <= xform_row;
                    end
                end
                xform_row: begin
                    row_idx <= row_idx + 2'd1;
                    if (row_idx == 2'd3) begin
                        state <= xform_shade;
                    end
                end
                xform_shade: begin
                    state <= xform_output;
                end
                xform_output: begin
                    if (out_ready) begin
                        state <= accept ? xform_row : xform_idle;
                    end
                end
                default: state <= xform_idle;
            endcase
        end
    end

endmodule

//--- transform/vertex_fetch.sv
module vertex_fetch (
    input  logic                              clk,
    input  logic                              reset_n,
    render_ctrl_if.engine_fetch               ctrl,
    vertex_if.source                          vtx,
    output logic [render_pkg::mem_addr_w-1:0] mem_addr,
    output logic                              mem_read,
    input  logic [render_pkg::data_w-1:0]     mem_readdata,
    input  logic                              mem_rdvalid
);
    import render_pkg::*;

    fetch_state_e state;
    mem_addr_t    vert_addr;
    count_t       remaining;
    logic [1:0]   word_idx;
    vec3_t        staged;
    logic         out_free;

    // one read per issue cycle, next word follows rdvalid
    assign mem_read = (state == fetch_issue);
    assign mem_addr = vert_addr + mem_addr_t'({word_idx, 2'b00});

    // output slot empty or draining this cycle
    assign out_free = !vtx.valid || vtx.ready;

    always_ff @(posedge clk) begin
        if (state == fetch_wait_data && mem_rdvalid) begin
            case (word_idx)
                2'd0:    staged.x <= mem_readdata;
                2'd1:    staged.y <= mem_readdata;
                default: staged.z <= mem_readdata;
            endcase
        end
        if (state == fetch_hand_off && out_free) begin
            vtx.vertex <= staged;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= fetch_idle;
            vert_addr <= '0;
            remaining <= '0;
            word_idx  <= '0;
            vtx.valid <= 1'b0;
            vtx.last  <= 1'b0;
        end else begin
            if (vtx.valid && vtx.ready) begin
                vtx.valid <= 1'b0;
            end

            case (state)
                fetch_idle: begin
                    if (ctrl.req) begin
                        vert_addr <= ctrl.vertex_base;
                        remaining <= ctrl.vertex_count;
                        word_idx  <= '0;
                        state     <= fetch_issue;
                    end
                end
                fetch_issue: begin
                    state <= fetch_wait_data;
                end
                fetch_wait_data: begin
                    if (mem_rdvalid) begin
                        if (word_idx == 2'd2) begin
                            word_idx  <= '0;
                            vert_addr <= vert_addr + mem_addr_t'(vertex_stride);
                            state     <= fetch_hand_off;
                        end else begin
                            word_idx <= word_idx + 2'd1;
                            state    <= fetch_issue;
                        end
                    end
                end
                fetch_hand_off: begin
                    // staged vertex waits here under back-pressure
                    if (out_free) begin
                        vtx.valid <= 1'b1;
                        vtx.last  <= (remaining == count_t'(1));
                        remaining <= remaining - count_t'(1);
                        state     <= (remaining == count_t'(1)) ? fetch_done_wait : fetch_issue;
                    end
                end
                fetch_done_wait: begin
                    if (!ctrl.req) begin
                        state <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

endmodule

//--- config_regs/config_regs.sv
module config_regs (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [render_pkg::bus_addr_w-1:0] address,
    input  logic [render_pkg::data_w-1:0]     writedata,
    input  logic                              write,
    input  logic                              read,
    output logic [render_pkg::data_w-1:0]     readdata,
    render_ctrl_if.regs                       ctrl
);
    import render_pkg::*;

    mem_addr_t         vertex_base;
    count_t            vertex_count;
    mat4_t             mvp;
    vec3_t             light;
    logic              req;
    logic              done;
    logic              mvp_hit;
    logic              light_hit;
    logic              start_write;
    logic [data_w-1:0] read_word;

    // word aligned hits in the matrix and light windows
    assign mvp_hit = (address[bus_addr_w-1:6] == reg_mvp_base[bus_addr_w-1:6]) &&
                     (address[1:0] == 2'b00);
    assign light_hit = (address[bus_addr_w-1:4] == reg_light_base[bus_addr_w-1:4]) &&
                       (address[3:2] != 2'b11) && (address[1:0] == 2'b00);

    assign start_write = write && (address == reg_control) && writedata[0];

    assign ctrl.req          = req;
    assign ctrl.vertex_base  = vertex_base;
    assign ctrl.vertex_count = vertex_count;
    assign ctrl.mvp          = mvp;
    assign ctrl.light        = light;

    always_comb begin
        read_word = '0;
        if (address == reg_vertex_base) begin
            read_word = data_w'(vertex_base);
        end else if (address == reg_vertex_count) begin
            read_word = data_w'(vertex_count);
        end else if (address == reg_control) begin
            read_word = {{(data_w-1){1'b0}}, done};
        end else if (address == reg_id) begin
            read_word = id_value;
        end else if (mvp_hit) begin
            read_word = mvp[address[5:2]];
        end else if (light_hit) begin
            case (address[3:2])
                2'd0:    read_word = light.x;
                2'd1:    read_word = light.y;
                default: read_word = light.z;
            endcase
        end
    end

    // matrix and light words
    always_ff @(posedge clk) begin
        if (write && mvp_hit) begin
            mvp[address[5:2]] <= writedata;
        end
        if (write && light_hit) begin
            case (address[3:2])
                2'd0:    light.x <= writedata;
                2'd1:    light.y <= writedata;
                default: light.z <= writedata;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vertex_base  <= '0;
            vertex_count <= '0;
            req          <= 1'b0;
            done         <= 1'b0;
            readdata     <= '0;
        end else begin
            if (write && address == reg_vertex_base) begin
                vertex_base <= writedata[mem_addr_w-1:0];
            end
            if (write && address == reg_vertex_count) begin
                vertex_count <= writedata[$bits(count_t)-1:0];
            end

            // start only once the previous handshake has fully closed
            if (start_write && !req && !ctrl.ack) begin
                req  <= (vertex_count != '0);
                done <= (vertex_count == '0);
            end else if (req && ctrl.ack) begin
                req  <= 1'b0;
                done <= 1'b1;
            end

            if (read) begin
                readdata <= read_word;
            end
        end
    end

endmodule

//--- common/vertex_if.sv
interface vertex_if ();
    import render_pkg::*;

    logic  valid;
    logic  ready;
    vec3_t vertex;
    // final vertex of the job
    logic  last;

    modport source (
        output valid,
        output vertex,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  vertex,
        input  last,
        output ready
    );

endinterface

//--- common/render_ctrl_if.sv
interface render_ctrl_if ();
    import render_pkg::*;

    // four-phase start/done pair
    logic      req;
    logic      ack;

    // job settings, stable while req is high
    mem_addr_t vertex_base;
    count_t    vertex_count;
    mat4_t     mvp;
    vec3_t     light;

    modport regs (
        output req,
        output vertex_base,
        output vertex_count,
        output mvp,
        output light,
        input  ack
    );

    modport engine_fetch (
        input  req,
        input  vertex_base,
        input  vertex_count
    );

    modport engine_xform (
        input  req,
        input  mvp,
        input  light,
        output ack
    );

endinterface

//--- common/render_pkg.sv
package render_pkg;

    // bus and memory widths
    localparam int data_w     = 32;
    localparam int bus_addr_w = 16;
    localparam int mem_addr_w = 26;
    localparam int frac_bits  = 16;

    // host register map, byte offsets
    localparam logic [bus_addr_w-1:0] reg_vertex_base  = 16'h0000;
    localparam logic [bus_addr_w-1:0] reg_vertex_count = 16'h0004;
    localparam logic [bus_addr_w-1:0] reg_control      = 16'h0008;
    localparam logic [bus_addr_w-1:0] reg_mvp_base     = 16'h0200;
    localparam logic [bus_addr_w-1:0] reg_light_base   = 16'h0300;
    localparam logic [bus_addr_w-1:0] reg_id           = 16'h0500;

    localparam logic [data_w-1:0] id_value = 32'hdeadbeef;

    // x, y, z words back to back
    localparam int vertex_stride = 12;

    // signed Q16.16
    typedef logic signed [data_w-1:0] fix_t;
    typedef logic [mem_addr_w-1:0] mem_addr_t;
    typedef logic [15:0] count_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vec3_t;

    // element 4*row + col
    typedef fix_t [15:0] mat4_t;

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_issue,
        fetch_wait_data,
        fetch_hand_off,
        fetch_done_wait
    } fetch_state_e;

    typedef enum logic [1:0] {
        xform_idle,
        xform_row,
        xform_shade,
        xform_output
    } xform_state_e;

endpackage
